/* ecc_defines.svh */
`ifndef ECC_DEFINES_SVH
`define ECC_DEFINES_SVH

// Payload width of one protected word.
`define ECC_DATA_W  99

// Seven positional check bits plus the even-weight bit.
`define ECC_CHECK_W 8

// Codeword positions run from 1 to 106.
`define ECC_POS_W   7

`endif

/* ecc_pkg.sv */
`default_nettype none

`include "ecc_defines.svh"

package ecc_pkg;

    typedef logic [`ECC_DATA_W-1:0]  data_t;
    typedef logic [`ECC_CHECK_W-1:0] check_t;  // Also the syndrome width.
    typedef logic [`ECC_POS_W-1:0]   pos_t;

    typedef enum logic [1:0] {
        err_none,
        err_check,   // Single error in a check bit.
        err_data,    // Single error in a data bit.
        err_uncorr   // Two or more bits in error.
    } err_class_e;

    // Data sits at every position that is not a power of two.
    function automatic logic is_data_pos(input pos_t pos);
        return (pos != '0) && ((pos & (pos - 1'b1)) != '0) &&
               (int'(pos) <= `ECC_DATA_W + `ECC_POS_W);
    endfunction

    function automatic pos_t data_pos(input int idx);
        pos_t pos;
        int   cnt;
        pos = '0;
        cnt = 0;
        for (int p = 1; p < (1 << `ECC_POS_W); p++) begin
            if (is_data_pos(pos_t'(p))) begin
                if (cnt == idx) begin
                    pos = pos_t'(p);
                end
                cnt++;
            end
        end
        return pos;
    endfunction

    function automatic check_t calc_check(input data_t d);
        check_t c;
        pos_t   p;
        c = '0;
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            p = data_pos(i);
            for (int j = 0; j < `ECC_POS_W; j++) begin
                if (p[j]) begin
                    c[j] ^= d[i];
                end
            end
            if (~^p) begin
                c[`ECC_CHECK_W-1] ^= d[i];  // Even-weight positions.
            end
        end
        return c;
    endfunction

endpackage

`default_nettype wire

/* ecc_stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ecc_stage_if;

    ecc_pkg::data_t  data;      // Received word.
    ecc_pkg::check_t syndrome;  // Stored check XOR computed check.
    ecc_pkg::check_t check;     // Computed check bits.
    logic            bypass;

    modport producer (
        output data,
        output syndrome,
        output check,
        output bypass
    );

    modport decode (
        input syndrome
    );

    modport consumer (
        input data,
        input check,
        input bypass
    );

endinterface

`default_nettype wire

/* ecc_pipe_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_pipe_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    output logic in_ready,
    input  logic out_ready,
    output logic out_valid,
    output logic load_s1,
    output logic load_s2
);

    logic s1_valid;
    logic s2_valid;
    logic s2_ready;

    // Stage 2 frees up when empty or when its item leaves this cycle.
    assign s2_ready = !s2_valid || out_ready;

    // Stage 1 frees up when empty or when its item moves on.
    assign in_ready = !s1_valid || s2_ready;

    assign load_s1 = in_valid && in_ready;
    assign load_s2 = s1_valid && s2_ready;

    assign out_valid = s2_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s2_ready) begin
                s2_valid <= s1_valid;  // Empty bubble moves on too.
            end
            if (in_ready) begin
                s1_valid <= in_valid;
            end
        end
    end

    // Output item held until the sink takes it.
    out_hold_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid
    ) else $error("out_valid dropped before transfer");

    // No fill while both stages are full and stalled.
    no_load_full_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        s1_valid && s2_valid && !out_ready |-> !load_s1
    ) else $error("load_s1 while both stages full and stalled");

endmodule

`default_nettype wire

/* ecc_check_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_check_gen (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            load_s1,
    input  ecc_pkg::data_t  in_data,
    input  ecc_pkg::check_t in_check,
    input  logic            in_bypass,
    ecc_stage_if.producer   stage
);

    ecc_pkg::check_t calc_bits;

    // Encode path, also the reference for the syndrome.
    assign calc_bits = ecc_pkg::calc_check(in_data);

    // Stage-1 syndrome and bypass.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage.syndrome <= '0;
            stage.bypass   <= 1'b0;
        end else if (load_s1) begin
            stage.syndrome <= in_check ^ calc_bits;
            stage.bypass   <= in_bypass;
        end
    end

    always_ff @(posedge clk) begin
        if (load_s1) begin
            stage.data  <= in_data;
            stage.check <= calc_bits;  // Returned unchanged at the output.
        end
    end

endmodule

`default_nettype wire

/* ecc_syndrome_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ecc_defines.svh"

module ecc_syndrome_decode (
    ecc_stage_if.decode          stage,
    output ecc_pkg::data_t       mask,
    output ecc_pkg::err_class_e  err_class
);

    ecc_pkg::pos_t s;
    logic          even_bit;
    logic          one_bit;
    logic          data_hit;

    assign s        = stage.syndrome[`ECC_POS_W-1:0];
    assign even_bit = stage.syndrome[`ECC_CHECK_W-1];

    // Exactly one syndrome bit set.
    assign one_bit = (stage.syndrome != '0) &&
                     ((stage.syndrome & (stage.syndrome - 1'b1)) == '0);

    // Single data error: valid position, top bit matches its weight.
    assign data_hit = ecc_pkg::is_data_pos(s) && (even_bit == ~^s);

    always_comb begin
        if (stage.syndrome == '0) begin
            err_class = ecc_pkg::err_none;
        end else if (one_bit) begin
            err_class = ecc_pkg::err_check;  // Data left alone.
        end else if (data_hit) begin
            err_class = ecc_pkg::err_data;
        end else begin
            err_class = ecc_pkg::err_uncorr;
        end
    end

    // One-hot at the data bit that lives at position s.
    always_comb begin
        mask = '0;
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            if ((err_class == ecc_pkg::err_data) && (ecc_pkg::data_pos(i) == s)) begin
                mask[i] = 1'b1;
            end
        end
    end

    // At most one data bit flipped per word.
    mask_onehot_a: assert final ($onehot0(mask))
        else $error("mask has more than one bit set");

    // Data errors and only data errors get a correction bit.
    mask_class_a: assert final ((mask != '0) == (err_class == ecc_pkg::err_data))
        else $error("mask does not match class %s", err_class.name());

endmodule

`default_nettype wire

/* ecc_corrector.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_corrector (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_s2,
    ecc_stage_if.consumer       stage,
    input  ecc_pkg::data_t      mask,
    input  ecc_pkg::err_class_e err_class,
    output ecc_pkg::data_t      out_data,
    output ecc_pkg::check_t     out_check,
    output logic                out_sbit_err,
    output logic                out_dbit_err
);

    logic sbit_next;
    logic dbit_next;

    assign sbit_next = !stage.bypass &&
                       ((err_class == ecc_pkg::err_check) ||
                        (err_class == ecc_pkg::err_data));
    assign dbit_next = !stage.bypass && (err_class == ecc_pkg::err_uncorr);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_sbit_err <= 1'b0;
            out_dbit_err <= 1'b0;
        end else if (load_s2) begin
            out_sbit_err <= sbit_next;
            out_dbit_err <= dbit_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_s2) begin
            out_data  <= stage.bypass ? stage.data : (stage.data ^ mask);
            out_check <= stage.check;
        end
    end

    // Flags never both high and the word altered only under the single flag.
    flags_consistent_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        load_s2 |=> !(out_sbit_err && out_dbit_err) &&
                    ((out_data == $past(stage.data)) || out_sbit_err)
    ) else $error("error flags disagree with the corrected word");

endmodule

`default_nettype wire

/* ecc_codec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_codec_top (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            in_valid,
    output logic            in_ready,
    input  ecc_pkg::data_t  in_data,
    input  ecc_pkg::check_t in_check,
    input  logic            in_bypass,

    output logic            out_valid,
    input  logic            out_ready,
    output ecc_pkg::data_t  out_data,
    output ecc_pkg::check_t out_check,
    output logic            out_sbit_err,
    output logic            out_dbit_err
);

    logic                load_s1;
    logic                load_s2;
    ecc_pkg::data_t      mask;
    ecc_pkg::err_class_e err_class;

    ecc_stage_if stage_if ();  // Stage-1 register contents.

    ecc_pipe_ctrl pipe_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .load_s1   (load_s1),
        .load_s2   (load_s2)
    );

    ecc_check_gen check_gen_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_s1   (load_s1),
        .in_data   (in_data),
        .in_check  (in_check),
        .in_bypass (in_bypass),
        .stage     (stage_if.producer)
    );

    ecc_syndrome_decode syndrome_decode_i (
        .stage     (stage_if.decode),
        .mask      (mask),
        .err_class (err_class)
    );

    ecc_corrector corrector_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_s2      (load_s2),
        .stage        (stage_if.consumer),
        .mask         (mask),
        .err_class    (err_class),
        .out_data     (out_data),
        .out_check    (out_check),
        .out_sbit_err (out_sbit_err),
        .out_dbit_err (out_dbit_err)
    );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;  // Released in the drive slot after the edge.
    end

endmodule

`default_nettype wire

/* ecc_codec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ecc_defines.svh"

module ecc_codec_tb;

    localparam logic [31:0] LFSR_SEED = 32'hd87d8007;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    localparam int N_VEC      = 40;
    localparam int N_BP       = 80;
    localparam int TOTAL_VEC  = 5 * N_VEC + N_BP;
    localparam int WD_CYCLES  = TOTAL_VEC * 20 + 100;
    localparam int CW_BITS    = `ECC_DATA_W + `ECC_CHECK_W;  // Data plus check bits.
    localparam int K_CLEAN    = 0;
    localparam int K_DATA     = 1;
    localparam int K_CHECK    = 2;
    localparam int K_DOUBLE   = 3;
    localparam int K_BYPASS   = 4;

    typedef struct packed {
        ecc_pkg::data_t  data;
        ecc_pkg::check_t check;
        logic            sbit;
        logic            dbit;
        logic            timed;     // Latency checked for this item.
        int unsigned     cyc;
    } exp_item_t;

    logic clk;
    logic rst_n;
    logic in_valid;
    logic in_ready;
    ecc_pkg::data_t  in_data;
    ecc_pkg::check_t in_check;
    logic in_bypass;
    logic out_valid;
    logic out_ready;
    ecc_pkg::data_t  out_data;
    ecc_pkg::check_t out_check;
    logic out_sbit_err;
    logic out_dbit_err;

    exp_item_t   exp_q[$];
    exp_item_t   drv_exp;
    exp_item_t   head;
    logic        head_valid;
    logic        in_taken;
    logic        out_taken;
    logic        ready_stop;
    logic [31:0] data_lfsr;
    logic [31:0] ready_lfsr;
    int unsigned cycle;
    int          errors;
    int          in_total;
    int          out_total;
    int          tests_passed;
    int          tests_failed;
    wire         out_fire = out_valid && out_ready;

    tb_clk_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(2)) clk_gen_i (.clk(clk), .rst_n(rst_n));

    ecc_codec_top dut_i (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
        .in_check(in_check), .in_bypass(in_bypass),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
        .out_check(out_check), .out_sbit_err(out_sbit_err), .out_dbit_err(out_dbit_err)
    );

    // Check bits straight from the placement rule, one position at a time.
    function automatic ecc_pkg::check_t ref_check(input ecc_pkg::data_t d);
        ecc_pkg::check_t c;
        int idx;
        c = '0;
        idx = 0;
        for (int pos = 1; idx < `ECC_DATA_W; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                for (int j = 0; j < `ECC_CHECK_W - 1; j++) begin
                    if (((pos >> j) & 1) == 1) c[j] = c[j] ^ d[idx];
                end
                if (($countones(pos) % 2) == 0) c[`ECC_CHECK_W-1] = c[`ECC_CHECK_W-1] ^ d[idx];
                idx++;
            end
        end
        return c;
    endfunction

    function automatic logic [127:0] take_bits(inout logic [31:0] state, input int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            state = state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
            v = {v[126:0], state[0]};
        end
        return v;
    endfunction

    function automatic int rand_below(input int n);
        logic [127:0] r;
        r = take_bits(data_lfsr, 7);
        return int'(r[6:0]) % n;
    endfunction

    // Index below the data width hits data, the rest hits check bits.
    function automatic void flip_bit(inout ecc_pkg::data_t d, inout ecc_pkg::check_t c,
                                     input int idx);
        if (idx < `ECC_DATA_W) d[idx] = ~d[idx];
        else c[idx-`ECC_DATA_W] = ~c[idx-`ECC_DATA_W];
    endfunction

    task automatic send_vector(input int kind, input logic timed);
        ecc_pkg::data_t  orig;
        ecc_pkg::data_t  rx_data;
        ecc_pkg::check_t rx_check;
        logic [127:0]    raw;
        int              a;
        int              b;
        logic            took;
        raw = take_bits(data_lfsr, `ECC_DATA_W);
        orig = raw[`ECC_DATA_W-1:0];
        rx_data = orig;
        rx_check = ref_check(orig);
        drv_exp.sbit = 1'b0;
        drv_exp.dbit = 1'b0;
        in_bypass = 1'b0;
        case (kind)
            K_DATA: begin
                flip_bit(rx_data, rx_check, rand_below(`ECC_DATA_W));
                drv_exp.sbit = 1'b1;
            end
            K_CHECK: begin
                flip_bit(rx_data, rx_check, `ECC_DATA_W + rand_below(`ECC_CHECK_W));
                drv_exp.sbit = 1'b1;
            end
            K_DOUBLE: begin
                a = rand_below(CW_BITS);
                do b = rand_below(CW_BITS); while (b == a);
                flip_bit(rx_data, rx_check, a);
                flip_bit(rx_data, rx_check, b);
                drv_exp.dbit = 1'b1;
            end
            K_BYPASS: begin
                flip_bit(rx_data, rx_check, rand_below(CW_BITS));
                in_bypass = 1'b1;
            end
            default: ;
        endcase
        drv_exp.data  = (kind == K_DATA) ? orig : rx_data;
        drv_exp.check = ref_check(rx_data);  // Encode path sees the received word.
        drv_exp.timed = timed;
        in_data  = rx_data;
        in_check = rx_check;
        in_valid = 1'b1;
        took = 1'b0;
        while (!took) begin
            @(negedge clk);
            took = in_ready;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic pace_out_ready();
        logic [127:0] r;
        while (!ready_stop) begin
            @(posedge clk);
            #1;
            r = take_bits(ready_lfsr, 1);
            if (!ready_stop) out_ready = r[0];
        end
    endtask

    task automatic run_test(input string name, input int kind, input int count,
                            input logic backpress);
        int err0;
        int k;
        err0 = errors;
        if (backpress) begin
            ready_stop = 1'b0;
            fork
                begin
                    for (int v = 0; v < count; v++) begin
                        k = rand_below(5);
                        send_vector(k, 1'b0);
                    end
                    ready_stop = 1'b1;
                end
                pace_out_ready();
            join
            out_ready = 1'b1;
        end else begin
            for (int v = 0; v < count; v++) send_vector(kind, 1'b1);
        end
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        #1;
        totals_a: assert (in_total == out_total) else begin
            $display("Results lost or duplicated: %0d accepted, %0d delivered",
                     in_total, out_total);
            errors++;
        end
        if (errors == err0) tests_passed++;
        else tests_failed++;
        $display("test %-12s %0d vectors, %0d errors", name, count, errors - err0);
    endtask

    // Fire flags taken mid-cycle, applied at the next edge.
    always @(negedge clk) begin
        in_taken  = in_valid && in_ready;
        out_taken = out_valid && out_ready;
    end

    always @(posedge clk) begin
        exp_item_t item;
        if (out_taken) begin
            out_total++;
            if (exp_q.size() != 0) void'(exp_q.pop_front());
        end
        if (in_taken) begin
            item = drv_exp;
            item.cyc = cycle;
            exp_q.push_back(item);
            in_total++;
        end
        cycle++;
        head_valid = (exp_q.size() != 0);
        if (head_valid) head = exp_q[0];
    end

    data_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_fire |-> out_data == head.data)
    else begin
        $display("Mismatch at %0t: out_data got %h, expected %h",
                 $time, $sampled(out_data), $sampled(head.data));
        errors++;
    end

    check_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_fire |-> out_check == head.check)
    else begin
        $display("Mismatch at %0t: out_check got %h, expected %h",
                 $time, $sampled(out_check), $sampled(head.check));
        errors++;
    end

    sbit_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_fire |-> out_sbit_err == head.sbit)
    else begin
        $display("Mismatch at %0t: out_sbit_err got %b, expected %b",
                 $time, $sampled(out_sbit_err), $sampled(head.sbit));
        errors++;
    end

    dbit_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_fire |-> out_dbit_err == head.dbit)
    else begin
        $display("Mismatch at %0t: out_dbit_err got %b, expected %b",
                 $time, $sampled(out_dbit_err), $sampled(head.dbit));
        errors++;
    end

    latency_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_fire && head.timed |-> cycle == head.cyc + 2)
    else begin
        $display("Mismatch at %0t: output latency got %0d, expected 2",
                 $time, $sampled(cycle) - $sampled(head.cyc));
        errors++;
    end

    extra_out_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> head_valid)
    else begin
        $display("Output valid at %0t with no result outstanding", $time);
        errors++;
    end

    stall_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_data) && $stable(out_check))
    else begin
        $display("Output payload changed at %0t while stalled", $time);
        errors++;
    end

    reset_idle_a: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid && in_ready)
    else begin
        $display("Pipeline not idle at %0t right after reset", $time);
        errors++;
    end

    initial begin
        in_valid   = 1'b0;
        in_data    = '0;
        in_check   = '0;
        in_bypass  = 1'b0;
        out_ready  = 1'b1;
        ready_stop = 1'b1;
        data_lfsr  = LFSR_SEED;
        ready_lfsr = LFSR_SEED;
        in_taken   = 1'b0;
        out_taken  = 1'b0;
        head       = '0;
        head_valid = 1'b0;
        drv_exp    = '0;
        cycle = 0;
        errors = 0;
        in_total = 0;
        out_total = 0;
        tests_passed = 0;
        tests_failed = 0;
        @(posedge rst_n);
        @(posedge clk);
        #1;
        run_test("clean_word", K_CLEAN, N_VEC, 1'b0);
        run_test("data_single", K_DATA, N_VEC, 1'b0);
        run_test("check_single", K_CHECK, N_VEC, 1'b0);
        run_test("double_err", K_DOUBLE, N_VEC, 1'b0);
        run_test("bypass", K_BYPASS, N_VEC, 1'b0);
        run_test("backpressure", K_CLEAN, N_BP, 1'b1);
        $display("%0d tests passed, %0d tests failed, %0d check errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run did not complete", WD_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
ecc_pkg.sv
ecc_stage_if.sv
ecc_pipe_ctrl.sv
ecc_check_gen.sv
ecc_syndrome_decode.sv
ecc_corrector.sv
ecc_codec_top.sv
tb_clk_gen.sv
ecc_codec_tb.sv
